/* gfx_obj_cfg.svh */
`ifndef GFX_OBJ_CFG_SVH
`define GFX_OBJ_CFG_SVH

// object table size, one map bit per slot
`define GFX_OBJ_COUNT 32

// bits needed to number a slot
`define GFX_OBJ_IDX_W 5

// attribute fields, x / y / width / height share the coordinate width
`define GFX_COORD_W 8
`define GFX_COLOR_W 8

`endif

/* gfx_cmd_pkg.sv */
package gfx_cmd_pkg;

    `include "gfx_obj_cfg.svh"

    // opcodes as sent by the command source
    typedef enum logic [1:0] {
        OP_CREATE     = 2'b00,
        OP_DELETE     = 2'b01,
        OP_DELETE_ALL = 2'b10,
        OP_REF        = 2'b11
    } gfx_op_e;

    // command word held in the command stage between sample and pulse
    typedef struct packed {
        gfx_op_e                   op;
        logic [`GFX_OBJ_IDX_W-1:0] obj_num;
    } gfx_cmd_t;

endpackage

/* gfx_obj_pkg.sv */
package gfx_obj_pkg;

    `include "gfx_obj_cfg.svh"

    typedef logic [`GFX_OBJ_IDX_W-1:0] obj_idx_t;

    // highest slot number, reaching it while occupied means full
    localparam obj_idx_t OBJ_LAST = obj_idx_t'(`GFX_OBJ_COUNT - 1);

    // 40 bit attribute word, x in the top byte
    typedef struct packed {
        logic [`GFX_COORD_W-1:0] x;
        logic [`GFX_COORD_W-1:0] y;
        logic [`GFX_COORD_W-1:0] width;
        logic [`GFX_COORD_W-1:0] height;
        logic [`GFX_COLOR_W-1:0] colour;
    } obj_attr_t;

endpackage

/* obj_cmd_if.sv */
`timescale 1ns/100ps

interface obj_cmd_if import gfx_obj_pkg::*;;

    logic      crt;      // create, one cycle
    logic      del;      // delete one object
    logic      del_all;  // clear whole table
    logic      ref_rd;   // reference, read back attributes
    obj_idx_t  obj_num;
    obj_attr_t attr;
    logic      busy;     // allocator still scanning for a free slot
    logic      mem_full;

    // command stage side
    modport src (
        output crt, del, del_all, ref_rd, obj_num, attr,
        input  busy, mem_full
    );

    // allocator side
    modport sink (
        input  crt, del, del_all, ref_rd, obj_num, attr,
        output busy, mem_full
    );

endinterface

/* obj_addr_if.sv */
`timescale 1ns/100ps

interface obj_addr_if import gfx_obj_pkg::*;;

    obj_idx_t  addr;
    logic      addr_vld;  // one cycle per translated access
    logic      addr_new;  // 1 = write on create, 0 = read on reference
    obj_attr_t attr;      // only meaningful with addr_new

    modport src (
        output addr, addr_vld, addr_new, attr
    );

    modport sink (
        input  addr, addr_vld, addr_new, attr
    );

endinterface

/* cmd_stage.sv */
`timescale 1ns/100ps

module cmd_stage import gfx_cmd_pkg::*, gfx_obj_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  gfx_op_e   cmd_op,
    input  obj_idx_t  cmd_obj_num,
    input  obj_attr_t cmd_attr,
    output logic      cmd_ready,
    output logic      cmd_reject,
    obj_cmd_if.src    cmd,
    input  logic      rd_vld
);

    gfx_cmd_t  cmd_q;
    obj_attr_t attr_q;
    logic      cmd_vld_q;   // sampled command waiting to be issued
    logic      ref_wait;    // reference issued, store has not answered yet
    logic      take;
    logic      pulse_any;
    logic      is_crt;

    assign take      = cmd_valid & cmd_ready;   // strobes while not ready are dropped
    assign pulse_any = cmd.crt | cmd.del | cmd.del_all | cmd.ref_rd;
    assign is_crt    = cmd_vld_q && (cmd_q.op == OP_CREATE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_vld_q <= 1'b0;
        end else begin
            cmd_vld_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cmd_q.op      <= cmd_op;
            cmd_q.obj_num <= cmd_obj_num;
            attr_q        <= cmd_attr;
        end
    end

    // decode into single pulses, full is only looked at here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd.crt     <= 1'b0;
            cmd.del     <= 1'b0;
            cmd.del_all <= 1'b0;
            cmd.ref_rd  <= 1'b0;
            cmd_reject  <= 1'b0;
        end else begin
            cmd.crt     <= is_crt && !cmd.mem_full;
            cmd_reject  <= is_crt && cmd.mem_full;    // create dropped here
            cmd.del     <= cmd_vld_q && (cmd_q.op == OP_DELETE);
            cmd.del_all <= cmd_vld_q && (cmd_q.op == OP_DELETE_ALL);
            cmd.ref_rd  <= cmd_vld_q && (cmd_q.op == OP_REF);
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_vld_q) begin
            cmd.obj_num <= cmd_q.obj_num;
            cmd.attr    <= attr_q;
        end
    end

    // ready comes back only once the whole path is quiet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ready <= 1'b0;
            ref_wait  <= 1'b0;
        end else begin
            if (take) begin
                cmd_ready <= 1'b0;
            end else if (!cmd_vld_q && !pulse_any && !cmd.busy && !(ref_wait && !rd_vld)) begin
                cmd_ready <= 1'b1;
            end
            if (take && (cmd_op == OP_REF)) begin
                ref_wait <= 1'b1;
            end else if (rd_vld) begin
                ref_wait <= 1'b0;
            end
        end
    end

endmodule

/* object_allocator.sv */
`timescale 1ns/100ps
`include "gfx_obj_cfg.svh"

module object_allocator import gfx_obj_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    obj_cmd_if.sink                   cmd,
    obj_addr_if.src                   mem,
    output obj_idx_t                  obj_id,
    output logic                      obj_id_vld,
    output logic                      obj_mem_full,
    output logic                      scene_changed,
    output logic [`GFX_OBJ_COUNT-1:0] obj_map
);

    typedef enum logic {
        ST_IDLE,
        ST_SCAN
    } alloc_st_e;

    alloc_st_e st, nxt_st;
    obj_idx_t  nxt_obj;      // lowest free slot once the scan has settled
    logic      full_q;

    logic inc_nxt, load_nxt, clr_nxt;
    logic set_full, clr_full;
    logic map_set, map_clr, map_clr_all;
    logic drv_new, drv_ref;

    assign cmd.busy      = (st == ST_SCAN);
    assign cmd.mem_full  = full_q;
    assign obj_mem_full  = full_q;

    always_comb begin
        nxt_st      = st;
        inc_nxt     = 1'b0;
        load_nxt    = 1'b0;
        clr_nxt     = 1'b0;
        set_full    = 1'b0;
        clr_full    = 1'b0;
        map_set     = 1'b0;
        map_clr     = 1'b0;
        map_clr_all = 1'b0;
        drv_new     = 1'b0;
        drv_ref     = 1'b0;
        case (st)
            ST_IDLE: begin
                if (cmd.crt) begin
                    map_set = 1'b1;
                    drv_new = 1'b1;            // slot goes out as obj_id and address
                    if (nxt_obj == OBJ_LAST) begin
                        set_full = 1'b1;       // took the last slot
                    end else begin
                        inc_nxt = 1'b1;
                        nxt_st  = ST_SCAN;
                    end
                end else if (cmd.del) begin
                    map_clr  = 1'b1;
                    clr_full = 1'b1;
                    if (cmd.obj_num < nxt_obj) begin
                        load_nxt = 1'b1;       // keep pointing at the lowest hole
                    end
                end else if (cmd.del_all) begin
                    map_clr_all = 1'b1;
                    clr_nxt     = 1'b1;
                    clr_full    = 1'b1;
                end else if (cmd.ref_rd) begin
                    drv_ref = 1'b1;
                end
            end
            ST_SCAN: begin
                // everything below nxt_obj is taken, walk up to the first hole
                if (!obj_map[nxt_obj]) begin
                    nxt_st = ST_IDLE;
                end else if (nxt_obj == OBJ_LAST) begin
                    set_full = 1'b1;
                    nxt_st   = ST_IDLE;
                end else begin
                    inc_nxt = 1'b1;
                end
            end
            default: nxt_st = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st <= ST_IDLE;
        end else begin
            st <= nxt_st;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nxt_obj <= '0;
        end else if (clr_nxt) begin
            nxt_obj <= '0;
        end else if (load_nxt) begin
            nxt_obj <= cmd.obj_num;
        end else if (inc_nxt) begin
            nxt_obj <= nxt_obj + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_map       <= '0;
            full_q        <= 1'b0;
            scene_changed <= 1'b0;
        end else begin
            if (map_clr_all) begin
                obj_map <= '0;
            end else if (map_set) begin
                obj_map[nxt_obj] <= 1'b1;
            end else if (map_clr) begin
                obj_map[cmd.obj_num] <= 1'b0;
            end
            if (set_full) begin
                full_q <= 1'b1;
            end else if (clr_full) begin
                full_q <= 1'b0;
            end
            scene_changed <= map_set | map_clr | map_clr_all;   // any map write
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.addr_vld <= 1'b0;
            obj_id_vld   <= 1'b0;
        end else begin
            mem.addr_vld <= drv_new | drv_ref;
            obj_id_vld   <= drv_new;
        end
    end

    // slot number is the address, the store is one entry per object
    always_ff @(posedge clk) begin
        if (drv_new) begin
            mem.addr     <= nxt_obj;
            mem.addr_new <= 1'b1;
            mem.attr     <= cmd.attr;
            obj_id       <= nxt_obj;
        end else if (drv_ref) begin
            mem.addr     <= cmd.obj_num;
            mem.addr_new <= 1'b0;
        end
    end

endmodule

/* obj_attr_store.sv */
`timescale 1ns/100ps
`include "gfx_obj_cfg.svh"

module obj_attr_store import gfx_obj_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    obj_addr_if.sink  mem,
    output obj_attr_t rd_attr,
    output logic      rd_vld
);

    obj_attr_t attr_mem [0:`GFX_OBJ_COUNT-1];
    logic      wr_en;
    logic      rd_en;

    assign wr_en = mem.addr_vld & mem.addr_new;
    assign rd_en = mem.addr_vld & ~mem.addr_new;

    // written once per create, stale entries are simply overwritten later
    always_ff @(posedge clk) begin
        if (wr_en) begin
            attr_mem[mem.addr] <= mem.attr;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_attr <= attr_mem[mem.addr];   // held until the next reference
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= rd_en;
        end
    end

endmodule

/* gfx_obj_top.sv */
`timescale 1ns/100ps
`include "gfx_obj_cfg.svh"

module gfx_obj_top import gfx_cmd_pkg::*, gfx_obj_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    // command source
    input  logic                      cmd_valid,
    input  gfx_op_e                   cmd_op,
    input  obj_idx_t                  cmd_obj_num,
    input  obj_attr_t                 cmd_attr,
    output logic                      cmd_ready,
    output logic                      cmd_reject,
    // allocation result
    output obj_idx_t                  obj_id,
    output logic                      obj_id_vld,
    output logic                      obj_mem_full,
    output logic [`GFX_OBJ_COUNT-1:0] obj_map,
    output logic                      scene_changed,
    // attribute read back
    output obj_attr_t                 rd_attr,
    output logic                      rd_vld
);

    obj_cmd_if  cmd_bus ();
    obj_addr_if addr_bus ();

    cmd_stage cmd_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_obj_num (cmd_obj_num),
        .cmd_attr    (cmd_attr),
        .cmd_ready   (cmd_ready),
        .cmd_reject  (cmd_reject),
        .cmd         (cmd_bus.src),
        .rd_vld      (rd_vld)         // holds ready low until a reference returns
    );

    object_allocator object_allocator_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd_bus.sink),
        .mem           (addr_bus.src),
        .obj_id        (obj_id),
        .obj_id_vld    (obj_id_vld),
        .obj_mem_full  (obj_mem_full),
        .scene_changed (scene_changed),
        .obj_map       (obj_map)
    );

    obj_attr_store obj_attr_store_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem     (addr_bus.sink),
        .rd_attr (rd_attr),
        .rd_vld  (rd_vld)
    );

endmodule

/* gfx_obj_assert.sv */
`timescale 1ns/100ps
`include "gfx_obj_cfg.svh"

module gfx_obj_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      addr_vld,
    input logic                      crt,
    input logic                      del,
    input logic                      del_all,
    input logic                      ref_rd,
    input logic                      mem_full,
    input logic [`GFX_OBJ_COUNT-1:0] obj_map
);

    // each translated access is a single cycle pulse
    addr_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
        addr_vld |=> !addr_vld)
        else $error("addr_vld stayed high for two cycles");

    full_map: assert property (@(posedge clk) disable iff (!rst_n)
        mem_full |-> (&obj_map))
        else $error("full flag set while the map has a free slot");

    one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({crt, del, del_all, ref_rd}))
        else $error("more than one command pulse in a cycle");

endmodule

bind object_allocator gfx_obj_assert gfx_obj_assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr_vld (mem.addr_vld),
    .crt      (cmd.crt),
    .del      (cmd.del),
    .del_all  (cmd.del_all),
    .ref_rd   (cmd.ref_rd),
    .mem_full (obj_mem_full),
    .obj_map  (obj_map)
);

/* tb_gfx_obj.sv */
`timescale 1ns/100ps
`include "gfx_obj_cfg.svh"

module tb_gfx_obj import gfx_cmd_pkg::*, gfx_obj_pkg::*; ();

    localparam int TMO     = 200;   // cycles per wait, well above the longest scan
    localparam int W_READY = 0;
    localparam int W_ID    = 1;
    localparam int W_RD    = 2;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      cmd_valid;
    gfx_op_e                   cmd_op;
    obj_idx_t                  cmd_obj_num;
    obj_attr_t                 cmd_attr;
    logic                      cmd_ready;
    logic                      cmd_reject;
    obj_idx_t                  obj_id;
    logic                      obj_id_vld;
    logic                      obj_mem_full;
    logic [`GFX_OBJ_COUNT-1:0] obj_map;
    logic                      scene_changed;
    obj_attr_t                 rd_attr;
    logic                      rd_vld;

    logic [`GFX_OBJ_COUNT-1:0] model_map;   // one bit per live object
    obj_attr_t                 model_attr [0:`GFX_OBJ_COUNT-1];
    int                        seed;
    int                        exp_scene;
    int                        scene_cnt  = 0;
    int                        reject_cnt = 0;
    int                        id_cnt     = 0;

    always #2 clk = ~clk;

    gfx_obj_top gfx_obj_top_i (.*);

    // pulse counters sampled on the edge after each registered pulse
    always @(posedge clk) begin
        if (scene_changed) scene_cnt <= scene_cnt + 1;
        if (cmd_reject) reject_cnt <= reject_cnt + 1;
        if (obj_id_vld) id_cnt <= id_cnt + 1;
    end

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check(input string tname, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %0h actual %0h", tname, exp, act);
            stop_run();
        end
    endtask

    task automatic wait_for(input int sel, input string tname);
        int    n;
        logic  hit;
        string sig;
        n   = 0;
        hit = 1'b0;
        case (sel)
            W_READY: sig = "cmd_ready";
            W_ID:    sig = "obj_id_vld";
            default: sig = "rd_vld";
        endcase
        while (!hit) begin
            @(negedge clk);
            case (sel)
                W_READY: hit = cmd_ready;
                W_ID:    hit = obj_id_vld;
                default: hit = rd_vld;
            endcase
            n++;
            if (!hit && n > TMO) begin
                $display("Timeout in %s: %s never went high", tname, sig);
                stop_run();
            end
        end
    endtask

    // lowest clear bit of the model map
    function automatic obj_idx_t lowest_free(input logic [`GFX_OBJ_COUNT-1:0] m);
        obj_idx_t r;
        r = '0;
        for (int i = `GFX_OBJ_COUNT - 1; i >= 0; i--) begin
            if (!m[i]) r = obj_idx_t'(i);
        end
        return r;
    endfunction

    function automatic obj_attr_t rand_attr();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return obj_attr_t'(r[39:0]);
    endfunction

    task automatic send_cmd(input gfx_op_e op, input obj_idx_t num, input obj_attr_t attr,
                            input string tname);
        wait_for(W_READY, tname);
        @(posedge clk);
        cmd_valid   <= 1'b1;
        cmd_op      <= op;
        cmd_obj_num <= num;
        cmd_attr    <= attr;
        @(posedge clk);              // the DUT takes it on this edge
        cmd_valid   <= 1'b0;
    endtask

    // common checks once the DUT is idle again
    task automatic check_state(input string tname);
        wait_for(W_READY, tname);
        check(tname, 64'(model_map), 64'(obj_map));
        check(tname, 64'(&model_map), 64'(obj_mem_full));
        check(tname, 64'(exp_scene), 64'(scene_cnt));
    endtask

    task automatic do_create(input string tname);
        obj_idx_t  exp_id;
        obj_attr_t attr;
        exp_id = lowest_free(model_map);
        attr   = rand_attr();
        send_cmd(OP_CREATE, '0, attr, tname);
        wait_for(W_ID, tname);
        check(tname, 64'(exp_id), 64'(obj_id));
        model_map[exp_id]  = 1'b1;
        model_attr[exp_id] = attr;
        exp_scene++;
        check_state(tname);
    endtask

    task automatic do_delete(input string tname, input obj_idx_t idx);
        send_cmd(OP_DELETE, idx, '0, tname);
        model_map[idx] = 1'b0;
        exp_scene++;
        check_state(tname);
    endtask

    task automatic do_ref(input string tname, input obj_idx_t idx);
        send_cmd(OP_REF, idx, '0, tname);
        wait_for(W_RD, tname);
        check(tname, 64'(model_attr[idx]), 64'(rd_attr));
        check_state(tname);
    endtask

    task automatic create_rejected(input string tname);
        int rej0;
        int id0;
        rej0 = reject_cnt;
        id0  = id_cnt;
        send_cmd(OP_CREATE, '0, rand_attr(), tname);
        check_state(tname);          // map and scene count must not move
        check(tname, 64'(rej0 + 1), 64'(reject_cnt));
        check(tname, 64'(id0), 64'(id_cnt));
    endtask

    initial begin
        seed        = 52;
        exp_scene   = 0;
        model_map   = '0;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_op      = OP_CREATE;
        cmd_obj_num = '0;
        cmd_attr    = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_state("reset");

        repeat (8) do_create("sequential_ids");

        do_delete("lowest_free", 5'd3);
        do_delete("lowest_free", 5'd5);
        repeat (3) do_create("lowest_free");    // 3, 5, then a scan up to 8

        do_ref("ref_readback", 5'd3);
        do_ref("ref_readback", 5'd0);
        do_ref("ref_readback", 5'd8);

        while (!(&model_map)) do_create("fill_to_full");
        check("fill_to_full", 64'd1, 64'(obj_mem_full));
        create_rejected("create_when_full");
        do_delete("free_one", 5'd17);
        check("free_one", 64'd0, 64'(obj_mem_full));
        do_create("free_one");
        do_ref("free_one", 5'd17);

        send_cmd(OP_DELETE_ALL, '0, '0, "delete_all");
        model_map = '0;
        exp_scene++;
        check_state("delete_all");
        repeat (2) do_create("delete_all");

        $display("Done: no errors");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
gfx_cmd_pkg.sv
gfx_obj_pkg.sv
obj_cmd_if.sv
obj_addr_if.sv
cmd_stage.sv
object_allocator.sv
obj_attr_store.sv
gfx_obj_top.sv
gfx_obj_assert.sv
tb_gfx_obj.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_gfx_obj -o sim_gfx_obj
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_gfx_obj > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "FAIL: simulation ended without a result"
    exit 1
fi
echo "PASS"
exit 0
